// ==== logic/pbch_rx_pkg.sv ====
package pbch_rx_pkg;

    // --------------------
    // default widths and sizes
    // --------------------

    // one IQ component, real or imaginary
    localparam int IQ_DW = 16;

    // one soft bit
    localparam int LLR_DW = 8;

    // power of two
    localparam int FIFO_DEPTH = 32;

    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    // --------------------
    // encodings
    // --------------------

    // kind of symbol a sample belongs to
    typedef enum logic [1:0] {
        SYM_DATA = 2'd0,
        SYM_PBCH = 2'd1,
        SYM_SSS  = 2'd2,
        SYM_RSVD = 2'd3
    } symbol_type_e;

    // register byte addresses
    typedef enum logic [3:0] {
        REG_DATA   = 4'h0,
        REG_LEVEL  = 4'h4,
        REG_STATUS = 4'h8,
        REG_CTRL   = 4'hC
    } reg_addr_e;

endpackage

// ==== logic/llr_demap.sv ====
module llr_demap #(
    parameter int IQ_DW  = pbch_rx_pkg::IQ_DW,
    parameter int LLR_DW = pbch_rx_pkg::LLR_DW
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,

    input  logic                      iq_valid_i,
    output logic                      iq_ready_o,
    input  logic signed [IQ_DW-1:0]   iq_re_i,
    input  logic signed [IQ_DW-1:0]   iq_im_i,
    input  pbch_rx_pkg::symbol_type_e iq_type_i,

    output logic                      llr_valid_o,
    output logic signed [LLR_DW-1:0]  llr_o,
    output pbch_rx_pkg::symbol_type_e llr_type_o
);

    typedef enum logic {
        IDLE,
        EMIT_IM
    } state_e;

    state_e                  state_q;
    logic signed [IQ_DW-1:0] im_q;
    logic                    accept;

    // QPSK soft bit, keep the top LLR_DW bits of the component
    function automatic logic signed [LLR_DW-1:0] scale(input logic signed [IQ_DW-1:0] x);
        logic signed [IQ_DW-1:0] shifted;
        shifted = x >>> (IQ_DW - LLR_DW);
        return shifted[LLR_DW-1:0];
    endfunction

    // one sample every second cycle
    assign iq_ready_o = (state_q == IDLE);
    assign accept     = iq_valid_i && iq_ready_o;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= IDLE;
            llr_valid_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    llr_valid_o <= accept;
                    if (accept) begin
                        state_q <= EMIT_IM;
                    end
                end
                EMIT_IM: begin
                    llr_valid_o <= 1'b1;
                    state_q     <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // real part goes out first, imaginary part waits in im_q
    always_ff @(posedge clk_i) begin
        if (accept) begin
            llr_o      <= scale(iq_re_i);
            llr_type_o <= iq_type_i;
            im_q       <= iq_im_i;
        end else if (state_q == EMIT_IM) begin
            llr_o <= scale(im_q);
        end
    end

endmodule

// ==== logic/llr_fifo.sv ====
module llr_fifo #(
    parameter int LLR_DW     = pbch_rx_pkg::LLR_DW,
    parameter int FIFO_DEPTH = pbch_rx_pkg::FIFO_DEPTH
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,

    input  logic                            llr_valid_i,
    input  logic signed [LLR_DW-1:0]        llr_i,
    input  pbch_rx_pkg::symbol_type_e       llr_type_i,

    input  logic                            pop_i,
    input  logic                            flush_i,

    output logic signed [LLR_DW-1:0]        head_o,
    output logic [$clog2(FIFO_DEPTH):0]     level_o,
    output logic                            overflow_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic signed [LLR_DW-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]            wr_ptr_q;
    logic [AW-1:0]            rd_ptr_q;
    logic [AW:0]              level_q;
    logic                     overflow_q;

    logic push_req;
    logic full;
    logic push;
    logic pop;

    // only PBCH soft bits are kept
    assign push_req = llr_valid_i && (llr_type_i == pbch_rx_pkg::SYM_PBCH);
    assign full     = (level_q == (AW + 1)'(FIFO_DEPTH));

    // flush wins over push and pop
    assign push = push_req && !full && !flush_i;
    assign pop  = pop_i && !flush_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni || flush_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            level_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            case ({push, pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase

            // sticky until the next flush, a pop does not make room in time
            if (push_req && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= llr_i;
        end
    end

    // --------------------
    // outputs
    // --------------------

    assign head_o     = mem[rd_ptr_q];
    assign level_o    = level_q;
    assign overflow_o = overflow_q;

endmodule

// ==== logic/apb_regs.sv ====
module apb_regs #(
    parameter int FIFO_DEPTH = pbch_rx_pkg::FIFO_DEPTH,
    parameter int LLR_DW     = pbch_rx_pkg::LLR_DW
) (
    input  logic                                clk_i,
    input  logic                                reset_ni,

    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [pbch_rx_pkg::APB_AW-1:0]      paddr_i,
    input  logic [pbch_rx_pkg::APB_DW-1:0]      pwdata_i,
    output logic [pbch_rx_pkg::APB_DW-1:0]      prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,

    input  logic signed [LLR_DW-1:0]            head_i,
    input  logic [$clog2(FIFO_DEPTH):0]         level_i,
    input  logic                                overflow_i,

    output logic                                pop_o,
    output logic                                flush_o
);

    localparam int DW = pbch_rx_pkg::APB_DW;
    localparam int LW = $clog2(FIFO_DEPTH) + 1;

    logic          setup;
    logic          access;
    logic          empty;

    logic [DW-1:0] rdata_d;
    logic [DW-1:0] rdata_q;
    logic          err_d;
    logic          err_q;
    logic          pop_d;
    logic          pop_q;
    logic          flush_d;
    logic          flush_q;

    assign setup  = psel_i && !penable_i;
    assign access = psel_i && penable_i;
    assign empty  = (level_i == '0);

    // --------------------
    // address decode
    // --------------------

    always_comb begin
        rdata_d = '0;
        err_d   = 1'b0;
        pop_d   = 1'b0;
        flush_d = 1'b0;
        case (paddr_i)
            pbch_rx_pkg::REG_DATA: begin
                if (!pwrite_i) begin
                    if (empty) begin
                        err_d = 1'b1;
                    end else begin
                        rdata_d = {{(DW - LLR_DW){head_i[LLR_DW-1]}}, head_i};
                        pop_d   = 1'b1;
                    end
                end
            end
            pbch_rx_pkg::REG_LEVEL: begin
                rdata_d[LW-1:0] = level_i;
            end
            pbch_rx_pkg::REG_STATUS: begin
                rdata_d[1:0] = {empty, overflow_i};
            end
            pbch_rx_pkg::REG_CTRL: begin
                flush_d = pwrite_i && pwdata_i[0];
            end
            default: begin
                err_d = 1'b1;
            end
        endcase
    end

    // decoded in the setup cycle, only the APB side pops, so the
    // level cannot drop to zero before the access cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            err_q   <= 1'b0;
            pop_q   <= 1'b0;
            flush_q <= 1'b0;
        end else if (setup) begin
            err_q   <= err_d;
            pop_q   <= pop_d;
            flush_q <= flush_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (setup) begin
            rdata_q <= rdata_d;
        end
    end

    // no wait states
    assign pready_o  = access;
    assign pslverr_o = access && err_q;
    assign prdata_o  = rdata_q;
    assign pop_o     = access && pop_q;
    assign flush_o   = access && flush_q;

endmodule

// ==== logic/pbch_rx_top.sv ====
module pbch_rx_top #(
    parameter int IQ_DW      = pbch_rx_pkg::IQ_DW,
    parameter int LLR_DW     = pbch_rx_pkg::LLR_DW,
    parameter int FIFO_DEPTH = pbch_rx_pkg::FIFO_DEPTH
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,

    // equalized samples
    input  logic                            iq_valid_i,
    output logic                            iq_ready_o,
    input  logic signed [IQ_DW-1:0]         iq_re_i,
    input  logic signed [IQ_DW-1:0]         iq_im_i,
    input  pbch_rx_pkg::symbol_type_e       iq_type_i,

    // soft bit stream, all symbol types
    output logic                            llr_valid_o,
    output logic signed [LLR_DW-1:0]        llr_o,
    output pbch_rx_pkg::symbol_type_e       llr_type_o,

    // register port
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [pbch_rx_pkg::APB_AW-1:0]  paddr_i,
    input  logic [pbch_rx_pkg::APB_DW-1:0]  pwdata_i,
    output logic [pbch_rx_pkg::APB_DW-1:0]  prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o
);

    localparam int LW = $clog2(FIFO_DEPTH) + 1;

    logic signed [LLR_DW-1:0] head;
    logic [LW-1:0]            level;
    logic                     overflow;
    logic                     pop;
    logic                     flush;

    llr_demap #(
        .IQ_DW (IQ_DW),
        .LLR_DW(LLR_DW)
    ) u_llr_demap (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .iq_valid_i (iq_valid_i),
        .iq_ready_o (iq_ready_o),
        .iq_re_i    (iq_re_i),
        .iq_im_i    (iq_im_i),
        .iq_type_i  (iq_type_i),
        .llr_valid_o(llr_valid_o),
        .llr_o      (llr_o),
        .llr_type_o (llr_type_o)
    );

    llr_fifo #(
        .LLR_DW    (LLR_DW),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_llr_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .llr_valid_i(llr_valid_o),
        .llr_i      (llr_o),
        .llr_type_i (llr_type_o),
        .pop_i      (pop),
        .flush_i    (flush),
        .head_o     (head),
        .level_o    (level),
        .overflow_o (overflow)
    );

    apb_regs #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .LLR_DW    (LLR_DW)
    ) u_apb_regs (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .head_i    (head),
        .level_i   (level),
        .overflow_i(overflow),
        .pop_o     (pop),
        .flush_o   (flush)
    );

endmodule

// ==== dv/tb_pbch_rx.sv ====
module tb_pbch_rx;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int IQ_DW   = pbch_rx_pkg::IQ_DW;
    localparam int LLR_DW  = pbch_rx_pkg::LLR_DW;
    localparam int DEPTH   = pbch_rx_pkg::FIFO_DEPTH;
    localparam int TIMEOUT = 200;

    logic                      clk_i = 1'b0;
    logic                      reset_ni;
    logic                      iq_valid_i;
    logic                      iq_ready_o;
    logic signed [IQ_DW-1:0]   iq_re_i;
    logic signed [IQ_DW-1:0]   iq_im_i;
    pbch_rx_pkg::symbol_type_e iq_type_i;
    logic                      llr_valid_o;
    logic signed [LLR_DW-1:0]  llr_o;
    pbch_rx_pkg::symbol_type_e llr_type_o;
    logic                      psel_i;
    logic                      penable_i;
    logic                      pwrite_i;
    logic [3:0]                paddr_i;
    logic [31:0]               pwdata_i;
    logic [31:0]               prdata_o;
    logic                      pready_o;
    logic                      pslverr_o;

    integer                    seed = 4074;
    int                        errors = 0;
    int                        checks = 0;
    int                        npbch = 0;
    logic [31:0]               rdata;
    logic                      err;
    logic signed [LLR_DW-1:0]  exp_llr;

    // expected demapper output and expected FIFO contents
    logic signed [LLR_DW-1:0]  stream_q[$];
    pbch_rx_pkg::symbol_type_e stream_type_q[$];
    logic signed [LLR_DW-1:0]  fifo_q[$];

    always #50 clk_i = ~clk_i;

    pbch_rx_top #(
        .IQ_DW     (IQ_DW),
        .LLR_DW    (LLR_DW),
        .FIFO_DEPTH(DEPTH)
    ) u_pbch_rx_top (.*);

    // top LLR_DW bits of the component
    function automatic logic signed [LLR_DW-1:0] ref_llr(input logic signed [IQ_DW-1:0] x);
        return x[IQ_DW-1 -: LLR_DW];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timed out waiting for %s", what);
    endtask

    // --------------------
    // stimulus
    // --------------------

    task automatic send_sample(input pbch_rx_pkg::symbol_type_e t);
        logic signed [IQ_DW-1:0] re;
        logic signed [IQ_DW-1:0] im;
        int n;
        re = $random(seed);
        im = $random(seed);
        n = 0;
        @(posedge clk_i);
        iq_valid_i <= 1'b1;
        iq_re_i    <= re;
        iq_im_i    <= im;
        iq_type_i  <= t;
        @(negedge clk_i);
        while (!iq_ready_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!iq_ready_o) begin
            report_timeout("iq_ready_o");
        end else begin
            stream_q.push_back(ref_llr(re));
            stream_q.push_back(ref_llr(im));
            stream_type_q.push_back(t);
            stream_type_q.push_back(t);
            if (t == pbch_rx_pkg::SYM_PBCH) begin
                npbch++;
                // full FIFO drops the push
                if (fifo_q.size() < DEPTH) begin
                    fifo_q.push_back(ref_llr(re));
                end
                if (fifo_q.size() < DEPTH) begin
                    fifo_q.push_back(ref_llr(im));
                end
            end
        end
        @(posedge clk_i);
        iq_valid_i <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (stream_q.size() != 0 && n < TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        if (stream_q.size() != 0) begin
            report_timeout("the LLR stream to drain");
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata);
        int n;
        n = 0;
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);
        while (!pready_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!pready_o) begin
            report_timeout("pready_o");
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic read_check(input string name, input logic [3:0] addr,
                              input logic [31:0] exp_data, input logic exp_err);
        apb_xfer(1'b0, addr, 32'h0);
        check_value({name, " data"}, exp_data, rdata);
        check_value({name, " pslverr"}, exp_err, err);
    endtask

    // --------------------
    // scoreboard
    // --------------------

    always @(negedge clk_i) begin
        if (reset_ni === 1'b1 && llr_valid_o === 1'b1) begin
            if (stream_q.size() == 0) begin
                errors++;
                $display("An LLR came out of the demapper with none expected");
            end else begin
                check_value("llr stream", stream_q.pop_front(), llr_o);
                check_value("llr type", stream_type_q.pop_front(), llr_type_o);
            end
        end
    end

    initial begin
        reset_ni   = 1'b0;
        iq_valid_i = 1'b0;
        iq_re_i    = '0;
        iq_im_i    = '0;
        iq_type_i  = pbch_rx_pkg::SYM_DATA;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        repeat (3) @(posedge clk_i);
        reset_ni <= 1'b1;

        read_check("reset level", pbch_rx_pkg::REG_LEVEL, 32'd0, 1'b0);
        read_check("reset status", pbch_rx_pkg::REG_STATUS, 32'd2, 1'b0);
        read_check("reset data", pbch_rx_pkg::REG_DATA, 32'd0, 1'b1);

        // random mix of all symbol types
        for (int i = 0; i < 12; i++) begin
            send_sample(pbch_rx_pkg::symbol_type_e'(2'($random(seed))));
        end
        drain();
        read_check("pbch level", pbch_rx_pkg::REG_LEVEL, 2 * npbch, 1'b0);
        while (fifo_q.size() > 0) begin
            exp_llr = fifo_q.pop_front();
            read_check("pbch data", pbch_rx_pkg::REG_DATA, exp_llr, 1'b0);
        end

        // more PBCH soft bits than the FIFO holds
        for (int i = 0; i < DEPTH / 2 + 4; i++) begin
            send_sample(pbch_rx_pkg::SYM_PBCH);
        end
        drain();
        read_check("overflow level", pbch_rx_pkg::REG_LEVEL, DEPTH, 1'b0);
        read_check("overflow status", pbch_rx_pkg::REG_STATUS, 32'd1, 1'b0);
        repeat (DEPTH) begin
            exp_llr = fifo_q.pop_front();
            read_check("overflow data", pbch_rx_pkg::REG_DATA, exp_llr, 1'b0);
        end
        read_check("overflow past end", pbch_rx_pkg::REG_DATA, 32'd0, 1'b1);

        send_sample(pbch_rx_pkg::SYM_PBCH);
        drain();
        apb_xfer(1'b1, pbch_rx_pkg::REG_CTRL, 32'd1);
        check_value("flush pslverr", 32'd0, err);
        fifo_q.delete();
        read_check("flush level", pbch_rx_pkg::REG_LEVEL, 32'd0, 1'b0);
        read_check("flush status", pbch_rx_pkg::REG_STATUS, 32'd2, 1'b0);

        // unmapped address leaves the FIFO alone
        send_sample(pbch_rx_pkg::SYM_PBCH);
        drain();
        read_check("unmapped read", 4'h2, 32'd0, 1'b1);
        apb_xfer(1'b1, 4'h2, 32'hFFFF_FFFF);
        check_value("unmapped write pslverr", 32'd1, err);
        read_check("unmapped level", pbch_rx_pkg::REG_LEVEL, 32'd2, 1'b0);

        end_run();
    end

endmodule

// ==== verilog.f ====
logic/pbch_rx_pkg.sv
logic/llr_demap.sv
logic/llr_fifo.sv
logic/apb_regs.sv
logic/pbch_rx_top.sv
dv/tb_pbch_rx.sv

// ==== Bender.yml ====
package:
  name: pbch_rx

sources:
  - logic/pbch_rx_pkg.sv
  - logic/llr_demap.sv
  - logic/llr_fifo.sv
  - logic/apb_regs.sv
  - logic/pbch_rx_top.sv
  - target: simulation
    files:
      - dv/tb_pbch_rx.sv
